// ==== rtl/hram_seq_config.svh ====
`ifndef HRAM_SEQ_CONFIG_SVH
`define HRAM_SEQ_CONFIG_SVH

// ----------------------------------------------------------------------
// burst geometry
// ----------------------------------------------------------------------

// 16-bit beats per burst
`define HRAM_BURST_WORDS 64

// bytes per burst and the address step
`define HRAM_BURST_BYTES 128

// ----------------------------------------------------------------------
// bus widths
// ----------------------------------------------------------------------

`define HRAM_ADDR_W 32
`define HRAM_DATA_W 16

// source fifo fill count
`define HRAM_LEVEL_W 8

`endif

// ==== rtl/hram_seq_pkg.sv ====
`default_nettype none

`include "hram_seq_config.svh"

package hram_seq_pkg;

  // ----------------------------------------------------------------------
  // width types
  // ----------------------------------------------------------------------

  // byte address and file length
  typedef logic [`HRAM_ADDR_W-1:0] hram_addr_t;
  typedef logic [`HRAM_DATA_W-1:0] hram_data_t;
  typedef logic [`HRAM_LEVEL_W-1:0] hram_level_t;

  // one bit wider than the index to count up to a full burst
  typedef logic [$clog2(`HRAM_BURST_WORDS):0] hram_beat_cnt_t;

  // burst fsm
  typedef enum logic [2:0] {
    st_idle,
    st_cmd,
    st_write,
    st_read,
    st_wait_done
  } hram_state_e;

  // ----------------------------------------------------------------------
  // phy-side bundles
  // ----------------------------------------------------------------------

  // rw is 0 for write and 1 for read
  typedef struct packed {
    logic       valid;
    logic       rw;
    hram_addr_t addr;
  } hram_cmd_t;

  typedef struct packed {
    logic       valid;
    logic       last;
    hram_data_t data;
  } hram_wdata_t;

endpackage

`default_nettype wire

// ==== rtl/hram_burst_request.sv ====
`default_nettype none

`include "hram_seq_config.svh"

module hram_burst_request
  import hram_seq_pkg::*;
(
  input  wire         i_clk,
  input  logic        i_reset,
  input  logic        i_cmd_ready,
  input  hram_level_t i_fifo_level,
  input  logic        i_sink_ready,
  input  logic        i_rw,
  output logic        o_go
);

  // enough words queued for one full write burst
  localparam hram_level_t c_level_min = hram_level_t'(`HRAM_BURST_WORDS);

  logic r_level_ok;
  logic r_sink_ok;

  // ----------------------------------------------------------------------
  // registered gating flags
  // ----------------------------------------------------------------------

  // threshold compare kept off the fsm path
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_level_ok <= 1'b0;
      r_sink_ok  <= 1'b0;
    end else begin
      r_level_ok <= (i_fifo_level >= c_level_min);
      r_sink_ok  <= i_sink_ready;
    end
  end

  // ----------------------------------------------------------------------
  // start request
  // ----------------------------------------------------------------------

  // live phy ready gated by the flag of the current direction
  always_comb begin
    if (i_rw) begin
      o_go = i_cmd_ready & r_sink_ok;
    end else begin
      o_go = i_cmd_ready & r_level_ok;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/hram_burst_fsm.sv ====
`default_nettype none

`include "hram_seq_config.svh"

module hram_burst_fsm
  import hram_seq_pkg::*;
(
  input  wire         i_clk,
  input  logic        i_reset,
  input  logic        i_init_done,
  input  logic        i_go,
  input  logic        i_done,
  input  logic        i_rw,
  input  hram_data_t  i_wr_data,
  output logic        o_issue,
  output logic        o_burst_end,
  output logic        o_wr_pop,
  output hram_wdata_t o_wdata
);

  // beat index of the final pop in a burst
  localparam hram_beat_cnt_t c_last_beat = hram_beat_cnt_t'(`HRAM_BURST_WORDS - 1);

  hram_state_e    r_state;
  hram_beat_cnt_t r_beat_cnt;
  logic           r_issue;
  logic           r_pop;
  logic           r_wvalid;
  logic           r_wlast;
  hram_data_t     r_wdata_q;

  // ----------------------------------------------------------------------
  // burst state machine
  // ----------------------------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_state    <= st_idle;
      r_beat_cnt <= '0;
      r_issue    <= 1'b0;
      r_pop      <= 1'b0;
      r_wvalid   <= 1'b0;
      r_wlast    <= 1'b0;
    end else begin
      // command strobe is a single cycle
      r_issue  <= 1'b0;

      // beats trail their pop by one cycle
      r_wvalid <= r_pop;
      r_wlast  <= r_pop & (r_beat_cnt == c_last_beat);

      case (r_state)
        st_idle: begin
          if (i_init_done) begin
            r_state <= st_cmd;
          end
        end

        st_cmd: begin
          r_beat_cnt <= '0;
          if (i_go) begin
            r_issue <= 1'b1;
            if (i_rw) begin
              r_state <= st_read;
            end else begin
              r_state <= st_write;
              r_pop   <= 1'b1;
            end
          end
        end

        // one pop per cycle until the burst is drained
        st_write: begin
          r_beat_cnt <= r_beat_cnt + 1'b1;
          if (r_beat_cnt == c_last_beat) begin
            r_pop   <= 1'b0;
            r_state <= st_wait_done;
          end
        end

        // read data bypasses the sequencer
        st_read: begin
          r_state <= st_wait_done;
        end

        st_wait_done: begin
          if (i_done) begin
            r_state <= st_cmd;
          end
        end

        default: begin
          r_state <= st_idle;
        end
      endcase
    end
  end

  // write payload, sampled in the pop cycle
  always_ff @(posedge i_clk) begin
    if (r_pop) begin
      r_wdata_q <= i_wr_data;
    end
  end

  // ----------------------------------------------------------------------
  // outputs
  // ----------------------------------------------------------------------

  // lets the sequencer step on the same edge as the return to cmd
  assign o_burst_end = (r_state == st_wait_done) & i_done;

  assign o_issue  = r_issue;
  assign o_wr_pop = r_pop;

  always_comb begin
    o_wdata.valid = r_wvalid;
    o_wdata.last  = r_wlast;
    o_wdata.data  = r_wdata_q;
  end

endmodule

`default_nettype wire

// ==== rtl/hram_addr_sequencer.sv ====
`default_nettype none

`include "hram_seq_config.svh"

module hram_addr_sequencer
  import hram_seq_pkg::*;
(
  input  wire        i_clk,
  input  logic       i_reset,
  input  hram_addr_t i_file_len,
  input  logic       i_issue,
  input  logic       i_burst_end,
  output logic       o_rw,
  output hram_cmd_t  o_cmd
);

  localparam hram_addr_t c_step = hram_addr_t'(`HRAM_BURST_BYTES);

  hram_addr_t r_addr;
  hram_addr_t r_last_addr;
  logic       r_rw;

  // start address of the final burst in the file
  always_ff @(posedge i_clk) begin
    r_last_addr <= i_file_len - c_step;
  end

  // ----------------------------------------------------------------------
  // address and direction stepping
  // ----------------------------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_addr <= '0;
      r_rw   <= 1'b0;
    end else if (i_burst_end) begin
      if (r_addr >= r_last_addr) begin
        // wrap to address 0 where write turns into read for good
        r_addr <= '0;
        r_rw   <= 1'b1;
      end else begin
        r_addr <= r_addr + c_step;
      end
    end
  end

  assign o_rw = r_rw;

  // command bundle toward the phy
  always_comb begin
    o_cmd.valid = i_issue;
    o_cmd.rw    = r_rw;
    o_cmd.addr  = r_addr;
  end

endmodule

`default_nettype wire

// ==== rtl/hram_seq_top.sv ====
`default_nettype none

module hram_seq_top
  import hram_seq_pkg::*;
(
  input  wire         w_clk_200m,
  input  logic        r_reset,

  // phy handshake
  input  logic        i_init_done,
  input  logic        i_cmd_ready,
  input  logic        i_done,

  // source fifo and sink
  input  hram_level_t i_fifo_level,
  input  logic        i_sink_ready,
  input  hram_data_t  i_wr_data,

  input  hram_addr_t  i_file_len,
  input  logic        i_restart,

  output hram_cmd_t   o_cmd,
  output hram_wdata_t o_wdata,
  output logic        o_wr_pop
);

  logic s_reset;
  logic s_go;
  logic s_issue;
  logic s_burst_end;
  logic s_rw;

  // soft restart behaves like the system reset
  assign s_reset = r_reset | i_restart;

  // ----------------------------------------------------------------------
  // decode, execute, result
  // ----------------------------------------------------------------------

  hram_burst_request u_request (
    .i_clk        (w_clk_200m),
    .i_reset      (s_reset),
    .i_cmd_ready  (i_cmd_ready),
    .i_fifo_level (i_fifo_level),
    .i_sink_ready (i_sink_ready),
    .i_rw         (s_rw),
    .o_go         (s_go)
  );

  hram_burst_fsm u_fsm (
    .i_clk       (w_clk_200m),
    .i_reset     (s_reset),
    .i_init_done (i_init_done),
    .i_go        (s_go),
    .i_done      (i_done),
    .i_rw        (s_rw),
    .i_wr_data   (i_wr_data),
    .o_issue     (s_issue),
    .o_burst_end (s_burst_end),
    .o_wr_pop    (o_wr_pop),
    .o_wdata     (o_wdata)
  );

  hram_addr_sequencer u_addr (
    .i_clk       (w_clk_200m),
    .i_reset     (s_reset),
    .i_file_len  (i_file_len),
    .i_issue     (s_issue),
    .i_burst_end (s_burst_end),
    .o_rw        (s_rw),
    .o_cmd       (o_cmd)
  );

endmodule

`default_nettype wire

// ==== tb/hram_phy_model.sv ====
`default_nettype none

module hram_phy_model
  import hram_seq_pkg::*;
(
  input  wire        i_clk,
  input  logic       i_init_en,
  input  logic       i_hold,
  input  logic [3:0] i_delay,
  input  hram_cmd_t  i_cmd,
  output logic       o_init_done,
  output logic       o_cmd_ready,
  output logic       o_done
);

  timeunit 1ns;
  timeprecision 100ps;

  int         init_cnt = 0;
  int         wait_cnt = 0;
  logic       busy = 1'b0;
  logic       cmd_seen;
  logic       cmd_rw;
  logic [3:0] dly;
  logic       en;
  logic       hold;

  initial begin
    o_init_done = 1'b0;
    o_cmd_ready = 1'b0;
    o_done      = 1'b0;
  end

  // inputs sampled at the edge and responses driven just after it
  always @(posedge i_clk) begin
    cmd_seen = i_cmd.valid;
    cmd_rw   = i_cmd.rw;
    dly      = i_delay;
    en       = i_init_en;
    hold     = i_hold;
    #2;
    o_done = 1'b0;
    // init completes a few cycles after enable
    if (!en) begin
      init_cnt    = 0;
      o_init_done = 1'b0;
    end else if (init_cnt < 4) begin
      init_cnt = init_cnt + 1;
    end else begin
      o_init_done = 1'b1;
    end
    // a write burst streams all its beats before done
    if (cmd_seen) begin
      busy     = 1'b1;
      wait_cnt = cmd_rw ? dly + 1 : dly + 64;
    end else if (busy && wait_cnt == 0) begin
      busy   = 1'b0;
      o_done = 1'b1;
    end else if (busy) begin
      wait_cnt = wait_cnt - 1;
    end
    o_cmd_ready = !busy && !hold;
  end

endmodule

`default_nettype wire

// ==== tb/tb_hram_seq.sv ====
`default_nettype none

`include "hram_seq_config.svh"

module tb_hram_seq
  import hram_seq_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int c_timeout = 2000;

  logic        w_clk_200m = 1'b0;
  logic        r_reset = 1'b1;
  logic        init_en = 1'b0;
  logic        hold = 1'b0;
  logic [3:0]  done_delay = '0;
  logic        init_done;
  logic        cmd_ready;
  logic        done;
  hram_level_t fifo_level = '0;
  logic        sink_ready = 1'b0;
  hram_data_t  wr_data = '0;
  hram_addr_t  file_len = 32'd512;
  logic        restart = 1'b0;
  hram_cmd_t   cmd;
  hram_wdata_t wdata;
  logic        wr_pop;

  logic [16:0] lfsr = 17'd86957;
  hram_data_t  fifo_q[$];
  hram_data_t  exp_data;
  logic        exp_rw = 1'b0;
  hram_addr_t  exp_addr = '0;
  logic        last_rw = 1'b0;
  logic        cmd_allowed = 1'b0;
  int          cmd_count = 0;
  int          done_count = 0;
  int          pops = 0;
  int          beats = 0;
  int          errors = 0;
  int          err_mark = 0;
  int          test_num = 1;
  int          tests_failed = 0;

  always #10 w_clk_200m = ~w_clk_200m;

  hram_seq_top u_dut (
    .w_clk_200m   (w_clk_200m),
    .r_reset      (r_reset),
    .i_init_done  (init_done),
    .i_cmd_ready  (cmd_ready),
    .i_done       (done),
    .i_fifo_level (fifo_level),
    .i_sink_ready (sink_ready),
    .i_wr_data    (wr_data),
    .i_file_len   (file_len),
    .i_restart    (restart),
    .o_cmd        (cmd),
    .o_wdata      (wdata),
    .o_wr_pop     (wr_pop)
  );

  hram_phy_model u_phy (
    .i_clk       (w_clk_200m),
    .i_init_en   (init_en),
    .i_hold      (hold),
    .i_delay     (done_delay),
    .i_cmd       (cmd),
    .o_init_done (init_done),
    .o_cmd_ready (cmd_ready),
    .o_done      (done)
  );

  // ----------------------------------------------------------------------
  // random source and reference model
  // ----------------------------------------------------------------------

  // fibonacci lfsr with taps at x^17 and x^14
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[16] ^ lfsr[13];
    lfsr = {lfsr[15:0], fb};
    return fb;
  endfunction

  function automatic hram_data_t rand_bits(input int n);
    hram_data_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | hram_data_t'(lfsr_step());
    end
    return v;
  endfunction

  // next burst position with the wrap into a read pass at end of file
  function automatic logic [`HRAM_ADDR_W:0] next_pos(input logic rw, input hram_addr_t addr,
                                                    input hram_addr_t len);
    hram_addr_t nxt;
    nxt = addr + `HRAM_BURST_BYTES;
    if (nxt >= len) begin
      return {1'b1, hram_addr_t'(0)};
    end
    return {rw, nxt};
  endfunction

  always @(posedge w_clk_200m) begin
    #2;
    wr_data    = rand_bits(16);
    done_delay = rand_bits(4);
  end

  // ----------------------------------------------------------------------
  // comparison
  // ----------------------------------------------------------------------

  always @(negedge w_clk_200m) begin
    if (!r_reset) begin
      assert (cmd_allowed || !(cmd.valid | wr_pop | wdata.valid)) else begin
        $display("ERR strobes while held: o_cmd.valid 0x%h o_wr_pop 0x%h o_wdata.valid 0x%h",
                 cmd.valid, wr_pop, wdata.valid);
        errors++;
      end
      if (cmd.valid) begin
        assert (cmd.rw == exp_rw && cmd.addr == exp_addr) else begin
          $display("ERR o_cmd: rw 0x%h addr 0x%h, expected rw 0x%h addr 0x%h",
                   cmd.rw, cmd.addr, exp_rw, exp_addr);
          errors++;
        end
        last_rw = exp_rw;
        {exp_rw, exp_addr} = next_pos(exp_rw, exp_addr, file_len);
        cmd_count++;
        pops  = 0;
        beats = 0;
      end
      if (wr_pop) begin
        fifo_q.push_back(wr_data);
        pops++;
      end
      if (wdata.valid && fifo_q.size() > 0) begin
        exp_data = fifo_q.pop_front();
        beats++;
        assert (wdata.data == exp_data) else begin
          $display("ERR o_wdata.data 0x%h, expected 0x%h", wdata.data, exp_data);
          errors++;
        end
        assert (wdata.last == (beats == `HRAM_BURST_WORDS)) else begin
          $display("ERR o_wdata.last 0x%h on beat 0x%h", wdata.last, beats);
          errors++;
        end
      end else begin
        assert (!wdata.valid && !wdata.last) else begin
          $display("ERR o_wdata valid 0x%h last 0x%h with no pop queued",
                   wdata.valid, wdata.last);
          errors++;
        end
      end
      // burst totals once the phy reports done
      if (done) begin
        assert (pops == (last_rw ? 0 : `HRAM_BURST_WORDS) && beats == pops) else begin
          $display("ERR burst totals: o_wr_pop count 0x%h, o_wdata beats 0x%h", pops, beats);
          errors++;
        end
        done_count++;
      end
    end
  end

  // ----------------------------------------------------------------------
  // sequencing helpers
  // ----------------------------------------------------------------------

  task automatic step(input int n);
    repeat (n) @(posedge w_clk_200m);
    #2;
  endtask

  task automatic finish_run();
    $display("tests %0d, failed %0d, errors %0d", test_num - 1, tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic wait_for_count(input bit dones, input int target);
    int n;
    n = 0;
    while ((dones ? done_count : cmd_count) < target && n < c_timeout) begin
      step(1);
      n++;
    end
    if ((dones ? done_count : cmd_count) < target) begin
      $display("timeout: %s number %0d never arrived", dones ? "done" : "command", target);
      errors++;
      finish_run();
    end
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: %0d errors", test_num, name, errors - err_mark);
      tests_failed++;
    end
    test_num++;
    err_mark = errors;
  endtask

  initial begin
    step(5);
    r_reset = 1'b0;

    // level is enough but init never came
    fifo_level = 8'd64;
    step(20);

    // init up with the level short so the fsm parks in cmd
    fifo_level = 8'd63;
    init_en    = 1'b1;
    step(20);

    // restart with init gone has to put the fsm back in idle
    init_en    = 1'b0;
    restart    = 1'b1;
    step(1);
    restart    = 1'b0;
    fifo_level = 8'd64;
    step(20);
    end_test("reset, restart and init hold");

    fifo_level = 8'd63;
    init_en    = 1'b1;
    step(40);
    cmd_allowed = 1'b1;
    fifo_level  = 8'd64;
    wait_for_count(1'b0, 1);
    end_test("fifo level gate");

    wait_for_count(1'b1, 4);
    cmd_allowed = 1'b0;
    end_test("write bursts");

    // sink low first and then the phy held back while the first read waits
    step(40);
    sink_ready = 1'b1;
    hold       = 1'b1;
    step(20);
    cmd_allowed = 1'b1;
    hold        = 1'b0;
    wait_for_count(1'b0, 5);
    end_test("sink gate and switch to read");

    wait_for_count(1'b0, 9);
    wait_for_count(1'b1, 9);
    end_test("read bursts with wrap");
    finish_run();
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/hram_seq_pkg.sv
rtl/hram_burst_request.sv
rtl/hram_burst_fsm.sv
rtl/hram_addr_sequencer.sv
rtl/hram_seq_top.sv
tb/hram_phy_model.sv
tb/tb_hram_seq.sv

// ==== Bender.yml ====
package:
  name: hram_seq

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/hram_seq_pkg.sv
      - rtl/hram_burst_request.sv
      - rtl/hram_burst_fsm.sv
      - rtl/hram_addr_sequencer.sv
      - rtl/hram_seq_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/hram_phy_model.sv
      - tb/tb_hram_seq.sv
